// File: rtl/limeIsaPkg.sv
`default_nettype none

package limeIsaPkg;

  localparam int dataWidth = 32;               // registers and instructions
  localparam int regAddrWidth = 5;             // 32 regs, r0 reads zero
  localparam int immWidth = 10;                // signed word offset
  localparam int shamtWidth = $clog2(dataWidth);

  // opcode, bits 2:0
  typedef enum logic [2:0] {
    opRType = 3'b000,
    opRiType = 3'b001, // reg-imm, also jalr and branches
    opIType = 3'b010,
    opNop = 3'b011,
    opJal = 3'b100,
    opHalt = 3'b111
  } opcodeT;

  // funct, bits 6:3; low two bits pick the branch compare
  typedef enum logic [3:0] {
    fnAdd = 4'h0, fnSub = 4'h1, fnAnd = 4'h2, fnOr = 4'h3,
    fnXor = 4'h4, fnSll = 4'h5, fnSrl = 4'h6, fnSla = 4'h7,
    fnSra = 4'h8, fnLw = 4'h9, fnSw = 4'hA, fnJalr = 4'hB,
    fnBeq = 4'hC, fnBne = 4'hD, fnBlt = 4'hE, fnBge = 4'hF
  } functT;

  typedef enum logic [3:0] {
    aluAdd = 4'h0, aluSub = 4'h1, aluAnd = 4'h2, aluOr = 4'h3,
    aluXor = 4'h4, aluSll = 4'h5, aluSrl = 4'h6, aluSla = 4'h7,
    aluSra = 4'h8,
    aluAddr = 4'h9, // load/store and jump target add
    aluPass = 4'hA, // a straight through, link value
    aluNone = 4'hF
  } aluOpT;

  typedef enum logic [3:0] {
    stFetch, stDecode, stRType, stRiType, stRTypeEnd, stLw1, stLw2,
    stSw, stJalr, stBranch, stBranch2, stJal,
    stHalted // also the idle state after reset
  } ctrlStateT;

  // msb first, so opcode lands on 2:0
  typedef struct packed {
    logic [immWidth-1:0] imm;     // 31:22
    logic [regAddrWidth-1:0] rs2; // 21:17
    logic [regAddrWidth-1:0] rs1; // 16:12
    logic [regAddrWidth-1:0] rd;  // 11:7
    functT funct;                 // 6:3
    opcodeT opcode;               // 2:0
  } instrT;

  // alu operand selects
  localparam logic [1:0] srcAPc = 2'd0;
  localparam logic [1:0] srcAReg = 2'd2; // anything else gives zero
  localparam logic [1:0] srcBReg = 2'd0;
  localparam logic [1:0] srcBOne = 2'd1;
  localparam logic [1:0] srcBImm = 2'd2;

endpackage

`default_nettype wire

// File: rtl/limeBusPkg.sv
`default_nettype none

package limeBusPkg;

  localparam int busDataWidth = 32;
  localparam int memDepth = 256;  // words
  localparam int memAddrWidth = 8; // word address
  localparam int apbAddrWidth = 12; // byte address on apb

  // memory window 0x000..0x3FC, one word per 4 bytes
  localparam logic [apbAddrWidth-1:0] memBase = 12'h000;
  localparam logic [apbAddrWidth-1:0] ctrlAddr = 12'h400;   // bit 0 start
  localparam logic [apbAddrWidth-1:0] statusAddr = 12'h404; // bit 0 halted, bit 1 running

endpackage

`default_nettype wire

// File: rtl/memBusIf.sv
`timescale 1ns/1ps
`default_nettype none

// req/ack word bus, requester holds everything steady until ack
interface memBusIf;
  import limeBusPkg::*;

  logic req;
  logic we;
  logic [memAddrWidth-1:0] addr;   // word address
  logic [busDataWidth-1:0] wdata;
  logic [busDataWidth-1:0] rdata;  // valid in ack cycle
  logic ack;                       // one cycle per transfer

  modport requester (
    output req, we, addr, wdata,
    input rdata, ack
  );

  modport memory (
    input req, we, addr, wdata,
    output rdata, ack
  );

endinterface

`default_nettype wire

// File: rtl/limeControl.sv
`timescale 1ns/1ps
`default_nettype none

module limeControl (
  input logic CLK,
  input logic Reset,
  input logic start,
  input limeIsaPkg::opcodeT opcode,
  input limeIsaPkg::functT funct,
  input logic memAck,
  input logic branchTaken,
  output limeIsaPkg::ctrlStateT state,
  output limeIsaPkg::aluOpT aluOp,
  output logic [1:0] aluSrcA,
  output logic [1:0] aluSrcB,
  output logic iorD,
  output logic irWrite,
  output logic memReq,
  output logic memWrite,
  output logic memToReg,
  output logic regWrite,
  output logic pcSrc,
  output logic pcWrite,
  output logic halted,
  output logic running
);
  import limeIsaPkg::*;

  ctrlStateT nextState;
  aluOpT functOp; // alu op decoded from funct

  always_ff @(posedge CLK or posedge Reset) begin
    if (Reset) begin
      state <= stHalted; // idle, wait for host start
      halted <= 1'b0;
    end else begin
      state <= nextState;
      if (state == stDecode && opcode == opHalt)
        halted <= 1'b1;
      else if (state == stHalted && start)
        halted <= 1'b0;
    end
  end

  assign running = (state != stHalted);

  always_comb begin
    case (funct)
      fnAdd: functOp = aluAdd;
      fnSub: functOp = aluSub;
      fnAnd: functOp = aluAnd;
      fnOr: functOp = aluOr;
      fnXor: functOp = aluXor;
      fnSll: functOp = aluSll;
      fnSrl: functOp = aluSrl;
      fnSla: functOp = aluSla;
      fnSra: functOp = aluSra;
      fnLw, fnSw: functOp = aluAddr; // effective address
      default: functOp = aluNone;
    endcase
  end

  // next state, memory states sit until memAck
  always_comb begin
    nextState = state;
    case (state)
      stHalted: if (start) nextState = stFetch;
      stFetch: if (memAck) nextState = stDecode;
      stDecode: begin
        case (opcode)
          opRType: nextState = stRType;
          opRiType: begin
            if (funct == fnJalr)
              nextState = stJalr;
            else if (funct inside {fnBeq, fnBne, fnBlt, fnBge})
              nextState = stBranch;
            else
              nextState = stRiType;
          end
          opIType: nextState = stRiType;
          opJal: nextState = stJal;
          opHalt: nextState = stHalted;
          default: nextState = stFetch; // nop and unused opcodes
        endcase
      end
      stRType: nextState = stRTypeEnd;
      stRiType: begin
        case (funct)
          fnLw: nextState = stLw1;
          fnSw: nextState = stSw;
          default: nextState = stRTypeEnd;
        endcase
      end
      stLw1: if (memAck) nextState = stLw2;
      stSw: if (memAck) nextState = stFetch;
      stBranch: nextState = stBranch2;
      default: nextState = stFetch; // rTypeEnd, lw2, jal, jalr, branch2
    endcase
  end

  always_comb begin
    aluOp = aluNone;
    aluSrcA = srcAPc;
    aluSrcB = srcBReg;
    iorD = 1'b0;
    irWrite = 1'b0;
    memReq = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    pcSrc = 1'b0;
    pcWrite = 1'b0;
    case (state)
      stFetch: begin
        memReq = 1'b1;
        aluOp = aluAdd; // pc + 1
        aluSrcB = srcBOne;
        irWrite = memAck;
        pcWrite = memAck;
      end
      stDecode: aluOp = aluPass; // aluOut <= pc, the link value
      stRType: begin
        aluOp = functOp;
        aluSrcA = srcAReg;
      end
      stRiType, stLw1, stSw: begin
        // same inputs in lw1/sw keep aluOut on the address
        aluOp = functOp;
        aluSrcA = srcAReg;
        aluSrcB = srcBImm;
        iorD = (state != stRiType);
        memReq = (state != stRiType);
        memWrite = (state == stSw);
      end
      stRTypeEnd: regWrite = 1'b1;
      stLw2: begin
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      stJal, stJalr: begin
        aluOp = aluAddr; // target straight into pc
        aluSrcA = (state == stJalr) ? srcAReg : srcAPc;
        aluSrcB = srcBImm;
        pcWrite = 1'b1;
        regWrite = 1'b1; // link from aluOut
      end
      stBranch: begin
        aluOp = aluAddr; // pc + imm into aluOut
        aluSrcB = srcBImm;
      end
      stBranch2: begin
        aluOp = aluSub;
        aluSrcA = srcAReg;
        pcSrc = 1'b1;
        pcWrite = branchTaken; // compare lives in the alu
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/limeAlu.sv
`timescale 1ns/1ps
`default_nettype none

module limeAlu (
  input logic [limeIsaPkg::dataWidth-1:0] a,
  input logic [limeIsaPkg::dataWidth-1:0] b,
  input limeIsaPkg::aluOpT op,
  input logic [1:0] branchType,
  output logic [limeIsaPkg::dataWidth-1:0] result,
  output logic branchTaken
);
  import limeIsaPkg::*;

  logic [shamtWidth-1:0] shamt;

  assign shamt = b[shamtWidth-1:0]; // low bits only

  always_comb begin
    case (op)
      aluAdd, aluAddr: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr: result = a | b;
      aluXor: result = a ^ b;
      aluSll, aluSla: result = a << shamt; // left shifts agree
      aluSrl: result = a >> shamt;
      aluSra: result = $signed(a) >>> shamt;
      aluPass: result = a;
      default: result = '0;
    endcase
  end

  // branch compare, signed for lt/ge
  always_comb begin
    case (branchType)
      2'b00: branchTaken = (a == b);  // beq
      2'b01: branchTaken = (a != b);  // bne
      2'b10: branchTaken = ($signed(a) < $signed(b));  // blt
      default: branchTaken = ($signed(a) >= $signed(b)); // bge
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/limeDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module limeDatapath (
  input logic CLK,
  input logic Reset,
  input logic start,
  output logic halted,
  output logic running,
  memBusIf.requester coreBus
);
  import limeIsaPkg::*;
  import limeBusPkg::*;

  ctrlStateT state;
  aluOpT aluOp;
  logic [1:0] aluSrcA;
  logic [1:0] aluSrcB;
  logic iorD, irWrite, memReq, memWrite, memToReg, regWrite, pcSrc, pcWrite;
  logic branchTaken;
  logic [1:0] branchType;
  logic [dataWidth-1:0] pc;      // word address
  logic [dataWidth-1:0] aluOut;  // registered alu result
  logic [dataWidth-1:0] dataReg; // load data
  logic [dataWidth-1:0] regA, regB, srcA, srcB, immExt, aluResult, wbData;
  instrT ir;
  logic [dataWidth-1:0] regFile [2**regAddrWidth];

  limeControl i_limeControl (
    .CLK, .Reset, .start,
    .opcode(ir.opcode),
    .funct(ir.funct),
    .memAck(coreBus.ack),
    .branchTaken,
    .state, .aluOp, .aluSrcA, .aluSrcB,
    .iorD, .irWrite, .memReq, .memWrite, .memToReg, .regWrite,
    .pcSrc, .pcWrite, .halted, .running
  );

  limeAlu i_limeAlu (
    .a(srcA),
    .b(srcB),
    .op(aluOp),
    .branchType,
    .result(aluResult),
    .branchTaken
  );

  assign branchType = ir.funct[1:0];
  assign immExt = {{(dataWidth-immWidth){ir.imm[immWidth-1]}}, ir.imm};
  assign regA = (ir.rs1 == '0) ? '0 : regFile[ir.rs1]; // r0 hardwired
  assign regB = (ir.rs2 == '0) ? '0 : regFile[ir.rs2];
  assign wbData = memToReg ? dataReg : aluOut;

  always_comb begin
    case (aluSrcA)
      srcAPc: srcA = pc;
      srcAReg: srcA = regA;
      default: srcA = '0;
    endcase
    case (aluSrcB)
      srcBReg: srcB = regB;
      srcBOne: srcB = {{(dataWidth-1){1'b0}}, 1'b1};
      srcBImm: srcB = immExt;
      default: srcB = '0;
    endcase
  end

  always_ff @(posedge CLK or posedge Reset) begin
    if (Reset)
      pc <= '0;
    else if (state == stHalted && start)
      pc <= '0; // every run starts at word 0
    else if (pcWrite)
      pc <= pcSrc ? aluOut : aluResult;
  end

  always_ff @(posedge CLK) begin
    aluOut <= aluResult;
    if (irWrite)
      ir <= instrT'(coreBus.rdata);
    if (coreBus.ack)
      dataReg <= coreBus.rdata;
    if (regWrite && ir.rd != '0)
      regFile[ir.rd] <= wbData;
  end

  // pc for fetch, aluOut for lw/sw
  assign coreBus.req = memReq;
  assign coreBus.we = memWrite;
  assign coreBus.addr = iorD ? aluOut[memAddrWidth-1:0] : pc[memAddrWidth-1:0];
  assign coreBus.wdata = regB; // store data from rs2

endmodule

`default_nettype wire

// File: rtl/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
  input logic CLK,
  input logic Reset,
  memBusIf.memory coreBus,
  memBusIf.memory hostBus,
  memBusIf.requester memBus
);

  logic busy;      // grant locked until ack
  logic lastHost;  // last winner, also owner while busy
  logic grantHost; // host side selected

  always_comb begin
    if (busy)
      grantHost = lastHost;
    else if (coreBus.req && hostBus.req)
      grantHost = ~lastHost; // round robin on a tie
    else
      grantHost = hostBus.req;
  end

  always_ff @(posedge CLK or posedge Reset) begin
    if (Reset) begin
      busy <= 1'b0;
      lastHost <= 1'b0;
    end else if (!busy && memBus.req) begin
      busy <= 1'b1;
      lastHost <= grantHost;
    end else if (busy && memBus.ack) begin
      busy <= 1'b0;
    end
  end

  assign memBus.req = grantHost ? hostBus.req : coreBus.req;
  assign memBus.we = grantHost ? hostBus.we : coreBus.we;
  assign memBus.addr = grantHost ? hostBus.addr : coreBus.addr;
  assign memBus.wdata = grantHost ? hostBus.wdata : coreBus.wdata;

  // only the owner sees ack and data
  assign coreBus.ack = memBus.ack & ~grantHost;
  assign hostBus.ack = memBus.ack & grantHost;
  assign coreBus.rdata = grantHost ? '0 : memBus.rdata;
  assign hostBus.rdata = grantHost ? memBus.rdata : '0;

endmodule

`default_nettype wire

// File: rtl/apbHostPort.sv
`timescale 1ns/1ps
`default_nettype none

module apbHostPort (
  input logic CLK,
  input logic Reset,
  input logic PSEL,
  input logic PENABLE,
  input logic PWRITE,
  input logic [limeBusPkg::apbAddrWidth-1:0] PADDR,
  input logic [limeBusPkg::busDataWidth-1:0] PWDATA,
  input logic halted,
  input logic running,
  output logic [limeBusPkg::busDataWidth-1:0] PRDATA,
  output logic PREADY,
  output logic PSLVERR,
  output logic start,
  memBusIf.requester hostBus
);
  import limeBusPkg::*;

  logic access; // apb access phase
  logic memSel, ctrlSel, statusSel;

  assign access = PSEL & PENABLE;
  assign memSel = (PADDR[apbAddrWidth-1:memAddrWidth+2] ==
                   memBase[apbAddrWidth-1:memAddrWidth+2]);
  assign ctrlSel = (PADDR == ctrlAddr);
  assign statusSel = (PADDR == statusAddr);

  // memory window waits for ack, registers answer at once
  assign PREADY = access & (memSel ? hostBus.ack : 1'b1);
  assign PSLVERR = access & ~(memSel | ctrlSel | statusSel);

  always_comb begin
    if (memSel)
      PRDATA = hostBus.rdata;
    else if (statusSel)
      PRDATA = {{(busDataWidth-2){1'b0}}, running, halted};
    else
      PRDATA = '0;
  end

  // start pulse, access phase of a register write is one cycle
  always_ff @(posedge CLK or posedge Reset) begin
    if (Reset)
      start <= 1'b0;
    else
      start <= access & PWRITE & ctrlSel & PWDATA[0];
  end

  assign hostBus.req = access & memSel; // held while PENABLE stays up
  assign hostBus.we = PWRITE;
  assign hostBus.addr = PADDR[memAddrWidth+1:2]; // byte to word
  assign hostBus.wdata = PWDATA;

endmodule

`default_nettype wire

// File: rtl/limeMemory.sv
`timescale 1ns/1ps
`default_nettype none

module limeMemory (
  input logic CLK,
  memBusIf.memory memBus
);
  import limeBusPkg::*;

  logic [busDataWidth-1:0] mem [memDepth]; // shared code and data

  // ack one cycle after req, no retrigger in the ack cycle
  always_ff @(posedge CLK) begin
    memBus.ack <= memBus.req & ~memBus.ack;
    if (memBus.req && !memBus.ack) begin
      if (memBus.we)
        mem[memBus.addr] <= memBus.wdata;
      memBus.rdata <= mem[memBus.addr]; // old word on a write
    end
  end

endmodule

`default_nettype wire

// File: rtl/limeTop.sv
`timescale 1ns/1ps
`default_nettype none

module limeTop (
  input logic CLK,
  input logic Reset,
  input logic PSEL,
  input logic PENABLE,
  input logic PWRITE,
  input logic [limeBusPkg::apbAddrWidth-1:0] PADDR,
  input logic [limeBusPkg::busDataWidth-1:0] PWDATA,
  output logic [limeBusPkg::busDataWidth-1:0] PRDATA,
  output logic PREADY,
  output logic PSLVERR
);

  logic start;   // host to core
  logic halted;  // core status back to host
  logic running;

  memBusIf coreBus ();
  memBusIf hostBus ();
  memBusIf memBus ();

  limeDatapath i_limeDatapath (
    .CLK, .Reset, .start,
    .halted, .running,
    .coreBus(coreBus.requester)
  );

  apbHostPort i_apbHostPort (
    .CLK, .Reset,
    .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .halted, .running,
    .PRDATA, .PREADY, .PSLVERR,
    .start,
    .hostBus(hostBus.requester)
  );

  memArbiter i_memArbiter (
    .CLK, .Reset,
    .coreBus(coreBus.memory),
    .hostBus(hostBus.memory),
    .memBus(memBus.requester)
  );

  limeMemory i_limeMemory (
    .CLK,
    .memBus(memBus.memory)
  );

endmodule

`default_nettype wire

// File: testbench/limeTb.sv
`timescale 1ns/1ps
`default_nettype none

module limeTb;
  import limeBusPkg::*;

  localparam int runBound = 2000; // cycles allowed per data record
  localparam int tdDepth = 256;

  logic CLK;
  logic Reset;
  logic PSEL;
  logic PENABLE;
  logic PWRITE;
  logic [apbAddrWidth-1:0] PADDR;
  logic [busDataWidth-1:0] PWDATA;
  logic [busDataWidth-1:0] PRDATA;
  logic PREADY;
  logic PSLVERR;

  logic [31:0] testData [tdDepth];  // records from the data file
  logic [31:0] shadow [memDepth];   // host-written words
  logic [7:0] wrAddr [8];
  logic [31:0] rngState;
  int recordCount;
  int checkCount;
  int errorCount;

  limeTop i_limeTop (
    .CLK, .Reset,
    .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .PRDATA, .PREADY, .PSLVERR
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK; // 4 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // walk the records once, kind 1 has a variable length
  function automatic int countRecords();
    int idx;
    int n;
    idx = 0;
    n = 0;
    while (idx < tdDepth - 3 && testData[idx] != 32'h0) begin
      if (testData[idx] == 32'h1)
        idx += 3 + int'(testData[idx+2]);
      else
        idx += 3;
      n++;
    end
    return n;
  endfunction

  // one apb transfer, random idle gap first
  task automatic apbTransfer(input logic wr, input logic [apbAddrWidth-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
    int waits;
    rngState = xorshift(rngState);
    repeat (rngState[1:0]) @(negedge CLK);
    @(negedge CLK);
    PSEL = 1'b1; // setup
    PENABLE = 1'b0;
    PWRITE = wr;
    PADDR = addr;
    PWDATA = wdata;
    @(negedge CLK);
    PENABLE = 1'b1; // access
    waits = 0;
    #1;
    while (!PREADY) begin
      @(negedge CLK);
      waits++;
      #1; // mid low phase, outputs settled
    end
    rdata = PRDATA;
    err = PSLVERR;
    checkCount++;
    // memory window needs two or more access cycles, registers just one
    assert ((addr[apbAddrWidth-1:apbAddrWidth-2] == 2'b00) ? (waits >= 1) : (waits == 0))
    else begin
      errorCount++;
      $display("The APB access to %03h ended after %0d wait cycles, wrong access timing",
               addr, waits);
    end
    @(negedge CLK); // transfer ended on the rising edge before
    PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic writeWord(input logic [7:0] word, input logic [31:0] value);
    logic [31:0] data;
    logic err;
    apbTransfer(1'b1, {2'b00, word, 2'b00}, value, data, err);
    checkCount++;
    assert (!err) else begin
      errorCount++;
      $display("Write to word %02h was answered with a slave error", word);
    end
  endtask

  task automatic checkWord(input logic [7:0] word, input logic [31:0] expected);
    logic [31:0] data;
    logic err;
    apbTransfer(1'b0, {2'b00, word, 2'b00}, 32'h0, data, err);
    checkCount++;
    assert (!err && data == expected) else begin
      errorCount++;
      $display("** Error at %0t ns: word %02h read %08h (slverr %0b), expected %08h",
               $time, word, data, err, expected);
    end
  endtask

  task automatic checkStatus(input logic [31:0] expected);
    logic [31:0] status;
    logic err;
    apbTransfer(1'b0, statusAddr, 32'h0, status, err);
    checkCount++;
    assert (!err && status == expected) else begin
      errorCount++;
      $display("** Error at %0t ns: status read %08h, expected %08h",
               $time, status, expected);
    end
  endtask

  // start the core, poll status until halted, optionally hammer a data word
  task automatic runProgram(input logic [7:0] pollWord, input logic [31:0] pollValue);
    logic [31:0] status;
    logic [31:0] data;
    logic err;
    apbTransfer(1'b1, ctrlAddr, 32'h1, data, err);
    checkStatus(32'h2); // running, not halted
    status = 32'h0;
    while (status != 32'h1) begin
      if (pollWord != 8'h00)
        checkWord(pollWord, pollValue); // contention with the core
      apbTransfer(1'b0, statusAddr, 32'h0, status, err);
    end
  endtask

  task automatic runTestdata();
    int idx;
    int i;
    logic [31:0] wordAddr;
    idx = 0;
    while (idx < tdDepth - 3 && testData[idx] != 32'h0) begin
      case (testData[idx])
        32'h1: begin // block of words from a base address
          for (i = 0; i < int'(testData[idx+2]); i++) begin
            wordAddr = testData[idx+1] + i;
            writeWord(wordAddr[7:0], testData[idx+3+i]);
          end
          idx += 3 + int'(testData[idx+2]);
        end
        32'h2: begin
          runProgram(testData[idx+1][7:0], testData[idx+2]);
          idx += 3;
        end
        32'h3: begin
          checkWord(testData[idx+1][7:0], testData[idx+2]);
          idx += 3;
        end
        default: begin
          errorCount++;
          $display("Unknown record kind %0h in the test data", testData[idx]);
          idx = tdDepth; // stop parsing
        end
      endcase
    end
  endtask

  task automatic randomReadback();
    int i;
    for (i = 0; i < 8; i++) begin
      rngState = xorshift(rngState);
      wrAddr[i] = {2'b11, rngState[5:0]}; // upper quarter, clear of programs
      rngState = xorshift(rngState);
      shadow[wrAddr[i]] = rngState;
      writeWord(wrAddr[i], shadow[wrAddr[i]]);
    end
    for (i = 0; i < 8; i++)
      checkWord(wrAddr[i], shadow[wrAddr[i]]); // repeats read the last value
  endtask

  task automatic unmappedAccess();
    logic [31:0] data;
    logic err;
    // aliases a tested word if decode were sloppy
    apbTransfer(1'b1, {2'b10, wrAddr[0], 2'b00}, ~shadow[wrAddr[0]], data, err);
    checkCount++;
    assert (err) else begin
      errorCount++;
      $display("A write to an unmapped address did not raise PSLVERR");
    end
    apbTransfer(1'b0, 12'h408, 32'h0, data, err);
    checkCount++;
    assert (err) else begin
      errorCount++;
      $display("A read from an unmapped address did not raise PSLVERR");
    end
    checkWord(wrAddr[0], shadow[wrAddr[0]]);
  endtask

  initial begin
    Reset = 1'b1;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    rngState = 32'd27;
    checkCount = 0;
    errorCount = 0;
    $readmemh("testbench/limeTestdata.txt", testData);
    recordCount = countRecords();
    repeat (10) @(negedge CLK);
    Reset = 1'b0;
    if (recordCount == 0) begin
      errorCount++;
      $display("No records could be read from the test data file");
    end
    checkStatus(32'h0); // idle after reset
    randomReadback();
    runTestdata();
    unmappedAccess();
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // watchdog, two extra slots for the register and unmapped tests
  initial begin
    #1;
    repeat ((recordCount + 2) * runBound) @(posedge CLK);
    $display("Timeout: the tests did not finish in %0d clock cycles",
             (recordCount + 2) * runBound);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/limeTestdata.txt
// hex records: 1 base count words = load words, 2 pollWord pollValue = start and wait,
// 3 word value = expected word, 0 = end; addresses in words
// arithmetic, logic and shifts, results at 0x80
1 00 13
19000082 FE400102 00041180 00041208 00041290 00041318 000413A0
0100142A 070024B2 00402542 20060051 20480051 208A0051 20CC0051
210E0051 21500051 21920051 21D40051 00000007
2 00 00000000
3 80 0000005D
3 81 0000006B
3 82 00000060
3 83 FFFFFFFD
3 84 FFFFFF9D
3 85 00000640
3 86 0000000F
3 87 FFFFFFFC
// bne loop, blt/bge, lw, jal and jalr
1 00 10
00000082 01400102 00401082 FF841069 24020051 00441071 00441079 24000051
240001C9 01000204 244A0051 24880051 24CC0051 00000007 00063280 00004359
2 00 00000000
3 90 00000005
3 91 0000000A
3 92 0000000A
3 93 00000010
// long lw loop, host polls word A1 meanwhile
1 A0 02 00000003 5A5A1234
1 00 0A
00000082 00000202 19000102 280001C9 00064200 00401082 FF041071 26080051
26420051 00000007
2 A1 5A5A1234
3 98 0000012C
3 99 00000064
3 A0 00000003
3 A1 5A5A1234
0

// File: vlog.f
rtl/limeIsaPkg.sv
rtl/limeBusPkg.sv
rtl/memBusIf.sv
rtl/limeControl.sv
rtl/limeAlu.sv
rtl/limeDatapath.sv
rtl/memArbiter.sv
rtl/apbHostPort.sv
rtl/limeMemory.sv
rtl/limeTop.sv
testbench/limeTb.sv

// File: run.sh
#!/bin/sh
# build the lime testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module limeTb \
  -f vlog.f -o limeSim \
  && ./obj_dir/limeSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
